//--- Makefile
# Verilator build and run for the divide unit testbench

TOP = div_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
		--top-module $(TOP) -f build.f -o $(TOP)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+verilog
+incdir+dv
verilog/div_op_pkg.sv
verilog/div_dp_pkg.sv
verilog/div_operand_prep.sv
verilog/div_restoring_core.sv
verilog/div_result_fix.sv
verilog/div_unit.sv
dv/div_unit_tb.sv

//--- dv/div_tests.svh
/*
 * directed tests for the divide unit
 * included inside the testbench module
 */
`ifndef DIV_TESTS_SVH
`define DIV_TESTS_SVH

// ==================================================
// value tests
// ==================================================
task automatic test_unsigned_dword();
  div_op_pkg::xlen_t dvd [7] = '{64'd100, 64'd5, 64'h1234_5678_9ABC_DEF0, {64{1'b1}},
                                 {64{1'b1}}, 64'h8000_0000_0000_0000, 64'hFEDC_BA98_7654_3210};
  div_op_pkg::xlen_t dvs [7] = '{64'd7, 64'd9, 64'd1, 64'd3,
                                 {64{1'b1}}, 64'h8000_0000_0000_0001, 64'h1_0000_0000};
  for (int i = 0; i < 7; i++) begin
    run_and_check($sformatf("divu pair %0d", i), OP_DIVU, dvd[i], dvs[i]);
    run_and_check($sformatf("remu pair %0d", i), OP_REMU, dvd[i], dvs[i]);
  end
endtask

task automatic test_signed_dword();
  div_op_pkg::xlen_t dvd [4] = '{64'd7, -64'sd7, 64'd7, -64'sd7};
  div_op_pkg::xlen_t dvs [4] = '{64'd2, 64'd2, -64'sd2, -64'sd2};
  div_op_pkg::xlen_t q_exp [4] = '{64'd3, -64'sd3, -64'sd3, 64'd3};  // toward zero
  div_op_pkg::xlen_t r_exp [4] = '{64'd1, -64'sd1, 64'd1, -64'sd1};  // sign of dividend
  div_op_pkg::xlen_t res;
  int                lat;
  for (int i = 0; i < 4; i++) begin
    run_op(OP_DIV, dvd[i], dvs[i], res, lat);
    check_result($sformatf("div signs %0d", i), q_exp[i], res);
    run_op(OP_REM, dvd[i], dvs[i], res, lat);
    check_result($sformatf("rem signs %0d", i), r_exp[i], res);
  end
  run_and_check("div large", OP_DIV, -64'sd81985529216486895, 64'd1000);
  run_and_check("rem large", OP_REM, -64'sd81985529216486895, 64'd1000);
endtask

// upper words carry garbage that must not leak into the result
task automatic test_word_ops();
  div_op_pkg::xlen_t dvd [3] = '{64'hDEAD_BEEF_FFFF_FFF9, 64'h5555_5555_8000_0010,
                                 64'h0123_4567_F000_0000};
  div_op_pkg::xlen_t dvs [3] = '{64'h1234_5678_0000_0002, 64'hAAAA_AAAA_0000_0010,
                                 64'hCAFE_F00D_0000_0001};
  div_op_pkg::xlen_t res;
  int                lat;
  for (int i = 0; i < 3; i++) begin
    run_and_check($sformatf("divw pair %0d", i), OP_DIVW, dvd[i], dvs[i]);
    run_and_check($sformatf("divuw pair %0d", i), OP_DIVUW, dvd[i], dvs[i]);
    run_and_check($sformatf("remw pair %0d", i), OP_REMW, dvd[i], dvs[i]);
    run_and_check($sformatf("remuw pair %0d", i), OP_REMUW, dvd[i], dvs[i]);
  end
  run_op(OP_DIVUW, dvd[2], dvs[2], res, lat);
  check_result("divuw bit 31 sext", 64'hFFFF_FFFF_F000_0000, res);
endtask

task automatic test_special_cases();
  div_op_pkg::div_op_t op;
  div_op_pkg::xlen_t   dvs;
  div_op_pkg::xlen_t   res;
  int                  lat;
  for (int k = 0; k < 8; k++) begin
    op  = 3'(k);
    dvs = op.is_word ? 64'hFFFF_FFFF_0000_0000 : 64'h0;  // zero low word only
    run_op(op, 64'h8765_4321_0FED_CBA9, dvs, res, lat);
    check_result($sformatf("div by zero op %0d", k),
                 model_div(op, 64'h8765_4321_0FED_CBA9, dvs), res);
    check_latency($sformatf("div by zero op %0d latency", k), 2, lat);
  end
  // most negative over minus one
  run_op(OP_DIV, 64'h8000_0000_0000_0000, {64{1'b1}}, res, lat);
  check_result("div overflow", 64'h8000_0000_0000_0000, res);
  check_latency("div overflow latency", 2, lat);
  run_op(OP_REM, 64'h8000_0000_0000_0000, {64{1'b1}}, res, lat);
  check_result("rem overflow", 64'h0, res);
  run_op(OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0001_FFFF_FFFF, res, lat);
  check_result("divw overflow", 64'hFFFF_FFFF_8000_0000, res);
  check_latency("divw overflow latency", 2, lat);
  run_op(OP_REMW, 64'h1234_5678_8000_0000, 64'h0000_0001_FFFF_FFFF, res, lat);
  check_result("remw overflow", 64'h0, res);
endtask

// ==================================================
// timing and handshake
// ==================================================
task automatic test_latency_backpressure();
  div_op_pkg::xlen_t res;
  div_op_pkg::xlen_t held;
  int                lat;
  run_op(OP_DIVW, 64'd100, 64'd7, res, lat);
  check_latency("divw latency", `DIV_ITER_W + 3, lat);
  issue_request(OP_DIVU, 64'd1000, 64'd10);
  lat = 0;
  @(negedge clk);              // accepting edge has passed
  req_valid = 1'b0;
  while (!result_valid) begin
    @(negedge clk);
    lat++;
    req_valid = (lat == 4);    // stray request mid-run
    if (lat == 4) begin
      if (!busy) stop_with_failure("busy_o low during a running divide");
      req.op       = OP_REMU;
      req.dividend = 64'd999;
      req.divisor  = 64'd4;
    end
    if (lat > WAIT_LIMIT) stop_with_failure("result_valid_o never rose after a request");
  end
  check_latency("divu latency", `DIV_ITER_D + 3, lat);
  held = result;
  check_result("divu with stray request", 64'd100, held);
  repeat (10) begin
    @(negedge clk);
    if (!result_valid || !busy) begin
      stop_with_failure("result_valid_o or busy_o fell while result_ready_i was low");
    end
    check_result("held result", held, result);
  end
  take_result(res);
  repeat (3) begin
    @(negedge clk);
    if (busy || result_valid) stop_with_failure("a request sent while busy was accepted");
  end
endtask

task automatic test_random();
  div_op_pkg::div_op_t op;
  div_op_pkg::xlen_t   a;
  div_op_pkg::xlen_t   b;
  for (int n = 0; n < 100; n++) begin
    op = 3'($urandom % 8);
    a  = {$urandom, $urandom};
    b  = {$urandom, $urandom} >> ($urandom % 64);  // spread of divisor sizes
    run_and_check($sformatf("random op %0d", n), op, a, b);
  end
endtask

`endif

//--- dv/div_unit_tb.sv
/*
 * testbench for the RV64 integer divide unit
 * directed and random divide and remainder operations,
 * checked for value and latency against a model built
 * from the RISC-V M-extension rules
 */
`timescale 1ns/10ps
`include "div_defines.svh"

module div_unit_tb;

  localparam int WAIT_LIMIT     = `DIV_ITER_D + 12;  // longest op plus slack
  localparam int TIMEOUT_CYCLES = 20000;  // ~150 ops x 67 cycles, about doubled

  // {is_rem, is_unsigned, is_word}
  localparam div_op_pkg::div_op_t OP_DIV   = 3'b000;
  localparam div_op_pkg::div_op_t OP_DIVW  = 3'b001;
  localparam div_op_pkg::div_op_t OP_DIVU  = 3'b010;
  localparam div_op_pkg::div_op_t OP_DIVUW = 3'b011;
  localparam div_op_pkg::div_op_t OP_REM   = 3'b100;
  localparam div_op_pkg::div_op_t OP_REMW  = 3'b101;
  localparam div_op_pkg::div_op_t OP_REMU  = 3'b110;
  localparam div_op_pkg::div_op_t OP_REMUW = 3'b111;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  div_op_pkg::div_req_t req;
  logic                 result_ready;
  logic                 busy;
  logic                 result_valid;
  div_op_pkg::xlen_t    result;
  int                   cycle_count;
  int                   checks_done;

  div_unit i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .result_ready_i (result_ready),
    .busy_o         (busy),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ==================================================
  // reference model
  // ==================================================
  function automatic div_op_pkg::xlen_t model_div(input div_op_pkg::div_op_t op,
                                                  input div_op_pkg::xlen_t a,
                                                  input div_op_pkg::xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] swa;
    logic signed [31:0] swb;
    logic [31:0]        wres;
    sa  = a;
    sb  = b;
    swa = a[31:0];
    swb = b[31:0];
    if (op.is_word) begin
      if (b[31:0] == 32'h0) wres = op.is_rem ? a[31:0] : 32'hFFFF_FFFF;
      else if (op.is_unsigned) wres = op.is_rem ? a[31:0] % b[31:0] : a[31:0] / b[31:0];
      else if (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hFFFF_FFFF)
        wres = op.is_rem ? 32'h0 : a[31:0];
      else wres = op.is_rem ? swa % swb : swa / swb;  // truncates toward zero
      return {{32{wres[31]}}, wres};
    end
    if (b == 64'h0) return op.is_rem ? a : {64{1'b1}};
    if (op.is_unsigned) return op.is_rem ? a % b : a / b;
    if (a == 64'h8000_0000_0000_0000 && b == {64{1'b1}}) return op.is_rem ? 64'h0 : a;
    return op.is_rem ? sa % sb : sa / sb;
  endfunction

  // 2 for divide by zero or overflow, otherwise prep + start + N + register
  function automatic int expected_latency(input div_op_pkg::div_op_t op,
                                          input div_op_pkg::xlen_t a,
                                          input div_op_pkg::xlen_t b);
    logic zero;
    logic ovf;
    if (op.is_word) begin
      zero = (b[31:0] == 32'h0);
      ovf  = !op.is_unsigned && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hFFFF_FFFF;
      return (zero || ovf) ? 2 : `DIV_ITER_W + 3;
    end
    zero = (b == 64'h0);
    ovf  = !op.is_unsigned && a == 64'h8000_0000_0000_0000 && b == {64{1'b1}};
    return (zero || ovf) ? 2 : `DIV_ITER_D + 3;
  endfunction

  // ==================================================
  // compare tasks
  // ==================================================
  task automatic check_result(input string name, input div_op_pkg::xlen_t exp,
                              input div_op_pkg::xlen_t act);
    checks_done++;
    if (act !== exp) begin
      stop_with_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    checks_done++;
    if (act != exp) begin
      stop_with_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // drive and handshake helpers
  task automatic issue_request(input div_op_pkg::div_op_t op, input div_op_pkg::xlen_t a,
                               input div_op_pkg::xlen_t b);
    @(negedge clk);
    if (busy) stop_with_failure("unit still busy when a new request was due");
    req_valid    = 1'b1;
    req.op       = op;
    req.dividend = a;
    req.divisor  = b;
  endtask

  // lat counts rising edges after the accepting edge
  task automatic wait_result(output int lat);
    lat = 0;
    @(negedge clk);    // request taken on the edge before
    req_valid = 1'b0;
    while (!result_valid) begin
      @(negedge clk);
      lat++;
      if (lat > WAIT_LIMIT) stop_with_failure("result_valid_o never rose after a request");
    end
  endtask

  task automatic take_result(output div_op_pkg::xlen_t res);
    res          = result;
    result_ready = 1'b1;
    @(negedge clk);
    result_ready = 1'b0;
  endtask

  task automatic run_op(input div_op_pkg::div_op_t op, input div_op_pkg::xlen_t a,
                        input div_op_pkg::xlen_t b, output div_op_pkg::xlen_t res,
                        output int lat);
    issue_request(op, a, b);
    wait_result(lat);
    take_result(res);
  endtask

  task automatic run_and_check(input string name, input div_op_pkg::div_op_t op,
                               input div_op_pkg::xlen_t a, input div_op_pkg::xlen_t b);
    div_op_pkg::xlen_t res;
    int                lat;
    run_op(op, a, b, res, lat);
    check_result(name, model_div(op, a, b), res);
    check_latency({name, " latency"}, expected_latency(op, a, b), lat);
  endtask

  `include "div_tests.svh"

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b1;    // reset is active high
    req_valid    = 1'b0;
    req          = '0;
    result_ready = 1'b0;
    cycle_count  = 0;
    checks_done  = 0;
    void'($urandom(9));
    repeat (8) @(negedge clk);
    if (busy || result_valid) stop_with_failure("busy_o or result_valid_o high in reset");
    check_result("reset result_o", '0, result);
    rst_n = 1'b0;
    test_unsigned_dword();
    test_signed_dword();
    test_word_ops();
    test_special_cases();
    test_latency_backpressure();
    test_random();
    @(negedge clk);
    if (checks_done > 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure("no result was checked during the run");
    end
  end

endmodule

//--- verilog/div_defines.svh
/*
 * divide unit sizing
 * data and word widths, and the iteration counts
 * used by the restoring shift-subtract core
 */
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// operand widths
`define DIV_XLEN   64
`define DIV_WLEN   32    // w forms use the low word

// one quotient bit per pass
`define DIV_ITER_D 64
`define DIV_ITER_W 32
`define DIV_CNT_W  7     // wide enough for DIV_ITER_D

`endif

//--- verilog/div_dp_pkg.sv
/*
 * divide datapath types
 * conditioned operands from the prep stage and
 * the raw magnitudes returned by the restoring core
 */
package div_dp_pkg;

  // output of operand conditioning
  typedef struct packed {
    div_op_pkg::xlen_t dividend_mag;  // word forms sit in bits 63:32
    div_op_pkg::xlen_t divisor_mag;
    logic              neg_q;         // negate quotient at the end
    logic              neg_r;         // negate remainder at the end
    logic              is_special;    // divide by zero or overflow
    div_op_pkg::xlen_t special_res;   // final value when is_special
  } div_prep_t;

  // unsigned magnitudes out of the core
  typedef struct packed {
    div_op_pkg::xlen_t quotient;
    div_op_pkg::xlen_t remainder;
  } div_core_res_t;

endpackage

//--- verilog/div_op_pkg.sv
/*
 * ISA-facing divide types
 * data word, operation flags and the request
 * as captured when an operation starts
 */
`include "div_defines.svh"

package div_op_pkg;

  // architectural register width
  typedef logic [`DIV_XLEN-1:0] xlen_t;

  // three flags cover all eight M-extension divide ops
  //   div  000   divu  010   divw  001   divuw  011
  //   rem  100   remu  110   remw  101   remuw  111
  // bit order is {is_rem, is_unsigned, is_word}
  typedef struct packed {
    logic is_rem;       // remainder instead of quotient
    logic is_unsigned;  // magnitudes taken as-is
    logic is_word;      // low 32 bits, sign-extended result
  } div_op_t;

  // request as seen at the start strobe
  typedef struct packed {
    div_op_t op;
    xlen_t   dividend;  // rs1
    xlen_t   divisor;   // rs2
  } div_req_t;

endpackage

//--- verilog/div_operand_prep.sv
/*
 * divide operand conditioning
 * extends word operands, forms two's-complement magnitudes,
 * works out the final sign flags and catches the divide by
 * zero and signed overflow cases with their RISC-V results
 */
`timescale 1ns/10ps
`include "div_defines.svh"

module div_operand_prep (
  input  div_op_pkg::div_req_t  req_i,
  output div_dp_pkg::div_prep_t prep_o
);

  div_op_pkg::div_op_t op;
  div_op_pkg::xlen_t   a_ext;      // dividend after word extension
  div_op_pkg::xlen_t   b_ext;      // divisor after word extension
  div_op_pkg::xlen_t   a_sext;     // sext of low dividend word
  div_op_pkg::xlen_t   a_mag;
  div_op_pkg::xlen_t   b_mag;
  div_op_pkg::xlen_t   base;       // dividend as the ISA reports it
  logic                a_neg;
  logic                b_neg;
  logic                min_neg;    // most negative dividend
  logic                div_zero;
  logic                div_ovf;

  assign op     = req_i.op;
  assign a_sext = {{(`DIV_XLEN-`DIV_WLEN){req_i.dividend[`DIV_WLEN-1]}},
                   req_i.dividend[`DIV_WLEN-1:0]};

  // ==================================================
  // extension and magnitudes
  // ==================================================
  always_comb begin
    a_ext = req_i.dividend;
    b_ext = req_i.divisor;
    if (op.is_word) begin
      if (op.is_unsigned) begin
        a_ext = {{(`DIV_XLEN-`DIV_WLEN){1'b0}}, req_i.dividend[`DIV_WLEN-1:0]};
        b_ext = {{(`DIV_XLEN-`DIV_WLEN){1'b0}}, req_i.divisor[`DIV_WLEN-1:0]};
      end else begin
        a_ext = a_sext;
        b_ext = {{(`DIV_XLEN-`DIV_WLEN){req_i.divisor[`DIV_WLEN-1]}},
                 req_i.divisor[`DIV_WLEN-1:0]};
      end
    end
  end

  assign a_neg = ~op.is_unsigned & a_ext[`DIV_XLEN-1];
  assign b_neg = ~op.is_unsigned & b_ext[`DIV_XLEN-1];
  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;

  // ==================================================
  // special cases
  // ==================================================
  assign div_zero = op.is_word ? (req_i.divisor[`DIV_WLEN-1:0] == '0)
                               : (req_i.divisor == '0);
  assign min_neg  = op.is_word ?
      (req_i.dividend[`DIV_WLEN-1:0] == {1'b1, {(`DIV_WLEN-1){1'b0}}}) :
      (req_i.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}});
  assign div_ovf  = ~op.is_unsigned & min_neg & (b_ext == '1);  // only -1 is all ones
  assign base     = op.is_word ? a_sext : req_i.dividend;

  always_comb begin
    prep_o.special_res = '0;
    if (div_zero) begin
      prep_o.special_res = op.is_rem ? base : '1;   // q = all ones, r = dividend
    end else if (div_ovf) begin
      prep_o.special_res = op.is_rem ? '0 : base;   // q = dividend, r = 0
    end
  end

  // word dividend goes to the top of the low half so 32 passes suffice
  assign prep_o.dividend_mag = op.is_word ?
      {a_mag[`DIV_WLEN-1:0], {(`DIV_XLEN-`DIV_WLEN){1'b0}}} : a_mag;
  assign prep_o.divisor_mag  = b_mag;
  assign prep_o.neg_q        = a_neg ^ b_neg;
  assign prep_o.neg_r        = a_neg;            // remainder follows dividend
  assign prep_o.is_special   = div_zero | div_ovf;

endmodule

//--- verilog/div_restoring_core.sv
/*
 * restoring shift-subtract divider
 * one quotient bit per cycle on unsigned magnitudes,
 * run length set by the iteration count loaded at start
 */
`timescale 1ns/10ps
`include "div_defines.svh"

module div_restoring_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_i,
  input  div_op_pkg::xlen_t         dividend_i,
  input  div_op_pkg::xlen_t         divisor_i,
  input  logic [`DIV_CNT_W-1:0]     iter_i,
  output logic                      busy_o,
  output logic                      done_o,
  output div_dp_pkg::div_core_res_t res_o
);

  logic [2*`DIV_XLEN-1:0] rq_q;        // {partial remainder, dividend / quotient}
  div_op_pkg::xlen_t      divisor_q;
  logic [`DIV_CNT_W-1:0]  cnt_q;       // passes left
  logic                   done_q;
  logic [`DIV_XLEN:0]     part_rem;    // shifted remainder, one bit wider
  logic [`DIV_XLEN+1:0]   trial;
  logic                   q_bit;
  div_op_pkg::xlen_t      rem_next;
  logic                   running;

  // ==================================================
  // trial subtraction
  // ==================================================
  // the bit shifted out of the remainder must survive when the
  // divisor is above 2^63, hence the extra bit on part_rem
  assign part_rem = rq_q[2*`DIV_XLEN-1:`DIV_XLEN-1];
  assign trial    = {1'b0, part_rem} - {2'b00, divisor_q};
  assign q_bit    = ~trial[`DIV_XLEN+1];            // non-negative difference
  assign rem_next = q_bit ? trial[`DIV_XLEN-1:0]    // keep difference
                          : part_rem[`DIV_XLEN-1:0]; // restore
  assign running  = (cnt_q != '0);

  // ==================================================
  // control
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        cnt_q <= iter_i;
      end else if (running) begin
        cnt_q  <= cnt_q - 1'b1;
        done_q <= (cnt_q == 'd1);   // last pass
      end
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    if (start_i) begin
      rq_q      <= {{`DIV_XLEN{1'b0}}, dividend_i};
      divisor_q <= divisor_i;
    end else if (running) begin
      rq_q <= {rem_next, rq_q[`DIV_XLEN-2:0], q_bit};
    end
  end

  assign busy_o          = running;
  assign done_o          = done_q;
  assign res_o.quotient  = rq_q[`DIV_XLEN-1:0];
  assign res_o.remainder = rq_q[2*`DIV_XLEN-1:`DIV_XLEN];

endmodule

//--- verilog/div_result_fix.sv
/*
 * divide result fix-up
 * restores signs on the core magnitudes, picks quotient
 * or remainder and sign-extends word results
 */
`timescale 1ns/10ps
`include "div_defines.svh"

module div_result_fix (
  input  div_op_pkg::div_op_t       op_i,
  input  logic                      neg_q_i,
  input  logic                      neg_r_i,
  input  div_dp_pkg::div_core_res_t core_i,
  output div_op_pkg::xlen_t         result_o
);

  div_op_pkg::xlen_t quot;
  div_op_pkg::xlen_t rem;
  div_op_pkg::xlen_t sel;

  // truncation toward zero falls out of negating the magnitudes
  assign quot = neg_q_i ? -core_i.quotient : core_i.quotient;
  assign rem  = neg_r_i ? -core_i.remainder : core_i.remainder;

  assign sel  = op_i.is_rem ? rem : quot;

  // w forms report bit 31 across the upper word
  assign result_o = op_i.is_word ?
      {{(`DIV_XLEN-`DIV_WLEN){sel[`DIV_WLEN-1]}}, sel[`DIV_WLEN-1:0]} : sel;

endmodule

//--- verilog/div_unit.sv
/*
 * integer divide unit for the RV64 execute stage
 * covers div, divu, divw, divuw, rem, remu, remw, remuw
 * request captured in IDLE, operands prepared, then either
 * the special result or the restoring core result is
 * registered and held until the consumer takes it
 */
`timescale 1ns/10ps
`include "div_defines.svh"

module div_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid_i,
  input  div_op_pkg::div_req_t req_i,
  input  logic                 result_ready_i,
  output logic                 busy_o,
  output logic                 result_valid_o,
  output div_op_pkg::xlen_t    result_o
);

  typedef enum logic [1:0] {
    IDLE,
    PREP,    // operands conditioned from req_q
    RUN,     // special result or core iterations
    FINISH   // result held for the consumer
  } state_t;

  state_t                    state_q;
  state_t                    state_d;
  div_op_pkg::div_req_t      req_q;
  div_dp_pkg::div_prep_t     prep;
  div_dp_pkg::div_prep_t     prep_q;
  logic                      start_q;    // core start pulse
  logic [`DIV_CNT_W-1:0]     iter;
  logic                      core_done;
  div_dp_pkg::div_core_res_t core_res;
  div_op_pkg::xlen_t         fix_res;
  div_op_pkg::xlen_t         result_q;

  // ==================================================
  // state machine
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_valid_i) state_d = PREP;
      PREP:    state_d = RUN;
      RUN:     if (prep_q.is_special || core_done) state_d = FINISH;
      FINISH:  if (result_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q  <= IDLE;
      start_q  <= 1'b0;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      start_q <= (state_q == PREP) && !prep.is_special;  // one cycle only
      if (state_q == RUN) begin
        if (prep_q.is_special) begin
          result_q <= prep_q.special_res;
        end else if (core_done) begin
          result_q <= fix_res;
        end
      end
    end
  end

  // request and prepared operands
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_valid_i) begin
      req_q <= req_i;
    end
    if (state_q == PREP) begin
      prep_q <= prep;
    end
  end

  assign iter = req_q.op.is_word ? `DIV_CNT_W'(`DIV_ITER_W) : `DIV_CNT_W'(`DIV_ITER_D);

  // ==================================================
  // datapath
  // ==================================================
  div_operand_prep u_prep (
    .req_i  (req_q),
    .prep_o (prep)
  );

  div_restoring_core u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_q),
    .dividend_i (prep_q.dividend_mag),
    .divisor_i  (prep_q.divisor_mag),
    .iter_i     (iter),
    .busy_o     (),              // unit busy comes from the FSM
    .done_o     (core_done),
    .res_o      (core_res)
  );

  div_result_fix u_fix (
    .op_i     (req_q.op),
    .neg_q_i  (prep_q.neg_q),
    .neg_r_i  (prep_q.neg_r),
    .core_i   (core_res),
    .result_o (fix_res)
  );

  assign busy_o         = (state_q != IDLE);   // falls once result is taken
  assign result_valid_o = (state_q == FINISH);
  assign result_o       = result_q;

endmodule
